//--- hdl/corr_pkg.sv
package corr_pkg;

	////////////////////
	// Sample format
	////////////////////

	// Sixteen 3-bit signed samples per channel word, sample 0 in the low bits
	localparam int NSAMP = 16;
	localparam int SBITS = 3;
	localparam int NBITS = NSAMP * SBITS;

	// Delay sets evaluated per group
	localparam int NCORR = 4;

	typedef logic [NBITS-1:0] chan_word_t;

	// The three antenna channels of one group
	typedef struct packed {
		chan_word_t a;
		chan_word_t b;
		chan_word_t c;
	} ritc_group_t;

	// History windows of one group, oldest word in the lowest bits
	typedef struct packed {
		logic [2*NBITS-1:0] a_hist;
		logic [3*NBITS-1:0] b_hist;
		logic [4*NBITS-1:0] c_hist;
	} group_store_t;

	typedef logic [11:0] score_t;

	// Sample offsets into the B and C histories, A always starts at 0
	localparam int DELAY_B [NCORR] = '{30, 29, 29, 28};
	localparam int DELAY_C [NCORR] = '{42, 41, 40, 39};

	////////////////////
	// User bus
	////////////////////

	typedef struct packed {
		logic        wr;
		logic [10:0] addr;
		logic [31:0] wdata;
	} user_cmd_t;

	// Buffer word address is BUF_BASE + entry*4 + lane
	localparam logic [10:0] CTRL_ADDR = 11'h000;
	localparam logic [10:0] BUF_BASE  = 11'h400;

endpackage

//--- hdl/ritc_input_storage.sv
`timescale 1ns/100ps

module ritc_input_storage (
	input  logic                  sysclk_i,
	input  logic                  rst_i,
	input  corr_pkg::ritc_group_t  grp_i,
	output corr_pkg::group_store_t store_o
);

	import corr_pkg::*;

	logic [2*NBITS-1:0] a_hist;
	logic [3*NBITS-1:0] b_hist;
	logic [4*NBITS-1:0] c_hist;

	// New words enter at the top, so the oldest word sits in the low bits
	always_ff @(posedge sysclk_i) begin
		if (rst_i) begin
			a_hist <= '0;
			b_hist <= '0;
			c_hist <= '0;
		end else begin
			a_hist <= {grp_i.a, a_hist[2*NBITS-1:NBITS]};
			b_hist <= {grp_i.b, b_hist[3*NBITS-1:NBITS]};
			c_hist <= {grp_i.c, c_hist[4*NBITS-1:NBITS]};
		end
	end

	assign store_o.a_hist = a_hist;
	assign store_o.b_hist = b_hist;
	assign store_o.c_hist = c_hist;

endmodule

//--- hdl/quad_correlator.sv
`timescale 1ns/100ps

module quad_correlator (
	input  logic                   sysclk_i,
	input  logic                   rst_i,
	input  corr_pkg::group_store_t store_i,
	output corr_pkg::score_t       max_o
);

	import corr_pkg::*;

	// Sixteen squares of at most (3 * -4)^2 each add up to no more than 2304
	localparam int SCORE_MAX = 2304;

	logic signed [4:0] pos_sum [NCORR][NSAMP];
	logic signed [9:0] pos_sq  [NCORR][NSAMP];
	logic [7:0]        sq_q    [NCORR][NSAMP];
	score_t            score_c [NCORR];
	score_t            score_q [NCORR];
	score_t            pair_q  [2];
	score_t            max_q;

	////////////////////
	// Stage 1
	////////////////////

	for (genvar k = 0; k < NCORR; k++) begin : g_set
		localparam int OFS_B = DELAY_B[k];
		localparam int OFS_C = DELAY_C[k];
		for (genvar i = 0; i < NSAMP; i++) begin : g_pos
			assign pos_sum[k][i] = $signed(store_i.a_hist[SBITS*i +: SBITS])
			                     + $signed(store_i.b_hist[SBITS*(OFS_B+i) +: SBITS])
			                     + $signed(store_i.c_hist[SBITS*(OFS_C+i) +: SBITS]);
			assign pos_sq[k][i] = pos_sum[k][i] * pos_sum[k][i];
		end
	end

	// A square never exceeds 144, so the low eight bits hold it
	always_ff @(posedge sysclk_i) begin
		for (int k = 0; k < NCORR; k++) begin
			for (int i = 0; i < NSAMP; i++) begin
				sq_q[k][i] <= pos_sq[k][i][7:0];
			end
		end
	end

	////////////////////
	// Stage 2
	////////////////////

	always_comb begin
		for (int k = 0; k < NCORR; k++) begin
			score_c[k] = '0;
			for (int i = 0; i < NSAMP; i++) begin
				score_c[k] = score_c[k] + {4'd0, sq_q[k][i]};
			end
		end
	end

	always_ff @(posedge sysclk_i) begin
		score_q <= score_c;
	end

	////////////////////
	// Stages 3 and 4
	////////////////////

	// Two-level max tree over the four registered scores
	always_ff @(posedge sysclk_i) begin
		if (rst_i) begin
			pair_q[0] <= '0;
			pair_q[1] <= '0;
			max_q     <= '0;
		end else begin
			pair_q[0] <= (score_q[0] > score_q[1]) ? score_q[0] : score_q[1];
			pair_q[1] <= (score_q[2] > score_q[3]) ? score_q[2] : score_q[3];
			max_q     <= (pair_q[0] > pair_q[1]) ? pair_q[0] : pair_q[1];
		end
	end

	assign max_o = max_q;

	// No score may exceed sixteen maximal squares
	for (genvar k = 0; k < NCORR; k++) begin : g_chk
		a_score_range : assert property (@(posedge sysclk_i) disable iff (rst_i)
			score_q[k] <= SCORE_MAX);
	end

endmodule

//--- hdl/sample_buffer.sv
`timescale 1ns/100ps

module sample_buffer #(
	parameter int CAP_DEPTH = 64
) (
	input  logic                         sysclk_i,
	input  logic                         rst_i,
	input  logic                         sync_i,
	input  corr_pkg::chan_word_t         r0a_i,
	input  corr_pkg::chan_word_t         r1a_i,
	input  logic                         trig_i,
	input  logic                         clear_i,
	output logic                         done_o,
	output logic                         sync_latch_o,
	input  logic [$clog2(CAP_DEPTH)-1:0] rd_entry_i,
	input  logic [1:0]                   rd_lane_i,
	output logic [31:0]                  rd_data_o
);

	import corr_pkg::*;

	localparam int AW = $clog2(CAP_DEPTH);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_CAPT = 2'd1;
	localparam logic [1:0] ST_DONE = 2'd2;

	logic [1:0]         state;
	logic [AW:0]        wr_ptr;
	logic               sync_latch;
	logic [2*NBITS-1:0] mem [CAP_DEPTH];
	logic [2*NBITS-1:0] rd_entry;

	////////////////////
	// Capture control
	////////////////////

	always_ff @(posedge sysclk_i) begin
		if (rst_i || clear_i) begin
			state      <= ST_IDLE;
			wr_ptr     <= '0;
			sync_latch <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (trig_i) begin
						state  <= ST_CAPT;
						wr_ptr <= '0;
					end
				end
				ST_CAPT: begin
					wr_ptr <= wr_ptr + 1'b1;
					if (sync_i)
						sync_latch <= 1'b1;
					if (wr_ptr == CAP_DEPTH - 1)
						state <= ST_DONE;
				end
				default: begin
					// Done holds until software clears it
					state <= ST_DONE;
				end
			endcase
		end
	end

	// Each entry holds the R0 A word in the low half and the R1 A word in the high half
	always_ff @(posedge sysclk_i) begin
		if (state == ST_CAPT)
			mem[wr_ptr[AW-1:0]] <= {r1a_i, r0a_i};
	end

	assign done_o       = (state == ST_DONE);
	assign sync_latch_o = sync_latch;

	////////////////////
	// Readout
	////////////////////

	assign rd_entry = mem[rd_entry_i];

	always_ff @(posedge sysclk_i) begin
		case (rd_lane_i)
			2'd0:    rd_data_o <= rd_entry[31:0];
			2'd1:    rd_data_o <= rd_entry[63:32];
			2'd2:    rd_data_o <= rd_entry[95:64];
			default: rd_data_o <= 32'd0;
		endcase
	end

	a_ptr_bound : assert property (@(posedge sysclk_i) disable iff (rst_i)
		wr_ptr <= CAP_DEPTH);

	// Done is reached only after every entry has been written once
	a_done_full : assert property (@(posedge sysclk_i) disable iff (rst_i)
		(state == ST_DONE) |-> (wr_ptr == CAP_DEPTH));

endmodule

//--- hdl/user_bus_slave.sv
`timescale 1ns/100ps

module user_bus_slave #(
	parameter int CAP_DEPTH = 64
) (
	input  logic                         sysclk_i,
	input  logic                         rst_i,
	input  logic                         user_req_i,
	input  corr_pkg::user_cmd_t          user_cmd_i,
	output logic                         user_ack_o,
	output logic [31:0]                  user_rdata_o,
	output logic                         trig_o,
	output logic                         clear_o,
	input  logic                         done_i,
	input  logic                         sync_latch_i,
	output logic [$clog2(CAP_DEPTH)-1:0] rd_entry_o,
	output logic [1:0]                   rd_lane_o,
	input  logic [31:0]                  rd_data_i
);

	import corr_pkg::*;

	localparam int AW = $clog2(CAP_DEPTH);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_CMD  = 3'd1;
	localparam logic [2:0] S_BUFW = 3'd2;
	localparam logic [2:0] S_RESP = 3'd3;
	localparam logic [2:0] S_ACK  = 3'd4;
	localparam logic [2:0] S_DROP = 3'd5;

	logic [2:0]  state;
	user_cmd_t   cmd_q;
	logic        ack_q;
	logic [31:0] rdata_q;
	logic [10:0] buf_ofs;
	logic        is_ctrl;
	logic        is_buf;
	logic [31:0] status;

	// Address decode of the latched command
	assign buf_ofs = cmd_q.addr - BUF_BASE;
	assign is_ctrl = (cmd_q.addr == CTRL_ADDR);
	assign is_buf  = (cmd_q.addr >= BUF_BASE) && (buf_ofs < CAP_DEPTH * 4);
	assign status  = {28'd0, sync_latch_i, 1'b0, done_i, 1'b0};

	// Buffer address stays stable from the latched command
	assign rd_entry_o = buf_ofs[2 +: AW];
	assign rd_lane_o  = buf_ofs[1:0];

	always_ff @(posedge sysclk_i) begin
		if (rst_i) begin
			state   <= S_IDLE;
			ack_q   <= 1'b0;
			trig_o  <= 1'b0;
			clear_o <= 1'b0;
		end else begin
			trig_o  <= 1'b0;
			clear_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (user_req_i)
						state <= S_CMD;
				end
				S_CMD: begin
					if (is_buf && !cmd_q.wr) begin
						state <= S_BUFW;
					end else begin
						if (is_ctrl && cmd_q.wr) begin
							trig_o  <= cmd_q.wdata[0];
							clear_o <= cmd_q.wdata[2];
						end
						state <= S_RESP;
					end
				end
				S_BUFW: state <= S_RESP;
				S_RESP: begin
					ack_q <= 1'b1;
					state <= S_ACK;
				end
				S_ACK: begin
					if (!user_req_i)
						state <= S_DROP;
				end
				default: begin
					ack_q <= 1'b0;
					state <= S_IDLE;
				end
			endcase
		end
	end

	// The command is latched with the request and the read data before ack rises
	always_ff @(posedge sysclk_i) begin
		if (state == S_IDLE && user_req_i)
			cmd_q <= user_cmd_i;
		if (state == S_CMD)
			rdata_q <= (is_ctrl && !cmd_q.wr) ? status : 32'd0;
		else if (state == S_BUFW)
			rdata_q <= rd_data_i;
	end

	assign user_ack_o   = ack_q;
	assign user_rdata_o = rdata_q;

	a_ack_needs_req : assert property (@(posedge sysclk_i) disable iff (rst_i)
		$rose(user_ack_o) |-> $past(user_req_i));

endmodule

//--- hdl/dual_ritc_correlator.sv
`timescale 1ns/100ps

module dual_ritc_correlator #(
	parameter int CAP_DEPTH = 64
) (
	input  logic                 sysclk_i,
	input  logic                 rst_i,
	input  logic                 sync_i,
	input  corr_pkg::ritc_group_t r0_i,
	input  corr_pkg::ritc_group_t r1_i,
	input  logic                 user_req_i,
	input  corr_pkg::user_cmd_t  user_cmd_i,
	output corr_pkg::score_t     r0_max_o,
	output corr_pkg::score_t     r1_max_o,
	output logic                 user_ack_o,
	output logic [31:0]          user_rdata_o
);

	import corr_pkg::*;

	group_store_t                 r0_store;
	group_store_t                 r1_store;
	logic                         trig;
	logic                         clear;
	logic                         done;
	logic                         sync_latch;
	logic [$clog2(CAP_DEPTH)-1:0] rd_entry;
	logic [1:0]                   rd_lane;
	logic [31:0]                  rd_data;

	////////////////////
	// Correlation path
	////////////////////

	ritc_input_storage u_store_r0 (
		.sysclk_i(sysclk_i), .rst_i(rst_i), .grp_i(r0_i), .store_o(r0_store)
	);

	ritc_input_storage u_store_r1 (
		.sysclk_i(sysclk_i), .rst_i(rst_i), .grp_i(r1_i), .store_o(r1_store)
	);

	quad_correlator u_corr_r0 (
		.sysclk_i(sysclk_i), .rst_i(rst_i), .store_i(r0_store), .max_o(r0_max_o)
	);

	quad_correlator u_corr_r1 (
		.sysclk_i(sysclk_i), .rst_i(rst_i), .store_i(r1_store), .max_o(r1_max_o)
	);

	////////////////////
	// Capture and bus
	////////////////////

	sample_buffer #(.CAP_DEPTH(CAP_DEPTH)) u_buffer (
		.sysclk_i(sysclk_i), .rst_i(rst_i), .sync_i(sync_i),
		.r0a_i(r0_i.a), .r1a_i(r1_i.a),
		.trig_i(trig), .clear_i(clear),
		.done_o(done), .sync_latch_o(sync_latch),
		.rd_entry_i(rd_entry), .rd_lane_i(rd_lane), .rd_data_o(rd_data)
	);

	user_bus_slave #(.CAP_DEPTH(CAP_DEPTH)) u_bus (
		.sysclk_i(sysclk_i), .rst_i(rst_i),
		.user_req_i(user_req_i), .user_cmd_i(user_cmd_i),
		.user_ack_o(user_ack_o), .user_rdata_o(user_rdata_o),
		.trig_o(trig), .clear_o(clear),
		.done_i(done), .sync_latch_i(sync_latch),
		.rd_entry_o(rd_entry), .rd_lane_o(rd_lane), .rd_data_i(rd_data)
	);

endmodule

//--- tb/tb_dual_ritc_correlator.sv
`timescale 1ns/100ps

module tb_dual_ritc_correlator;

	import corr_pkg::*;

	localparam int CAP_DEPTH   = 64;
	localparam int RST_CYCLES  = 5;
	localparam int CONST_STEPS = 10;
	localparam int N_PATTERNS  = 2;
	localparam int RAND_STEPS  = 200;
	localparam int CAP_STEPS   = 64;
	localparam int RECAP_STEPS = 70;
	localparam int BUS_OPS     = 30;
	// Worst case for one bus access, both ack waits running to their limit
	localparam int BUS_CYCLES  = 24;
	localparam int RUN_CYCLES  = RST_CYCLES + N_PATTERNS * CONST_STEPS + RAND_STEPS
	                           + CAP_STEPS + RECAP_STEPS + BUS_OPS * BUS_CYCLES;
	localparam int PROBE_ENTRIES [5] = '{0, 1, 17, 32, 63};

	logic        sysclk = 1'b0;
	logic        rst;
	logic        sync;
	ritc_group_t r0_in;
	ritc_group_t r1_in;
	logic        user_req;
	user_cmd_t   user_cmd;
	score_t      r0_max;
	score_t      r1_max;
	logic        user_ack;
	logic [31:0] user_rdata;

	// Every word the DUT sampled, indexed by rising edge, zero while in reset
	ritc_group_t g0_log [$];
	ritc_group_t g1_log [$];
	int          edge_cnt = 0;
	int          ack_edge = 0;
	logic [15:0] lfsr_state = 16'd45;

	dual_ritc_correlator #(.CAP_DEPTH(CAP_DEPTH)) UUT (
		.sysclk_i(sysclk), .rst_i(rst), .sync_i(sync),
		.r0_i(r0_in), .r1_i(r1_in),
		.user_req_i(user_req), .user_cmd_i(user_cmd),
		.r0_max_o(r0_max), .r1_max_o(r1_max),
		.user_ack_o(user_ack), .user_rdata_o(user_rdata)
	);

	always #50 sysclk = ~sysclk;

	always @(posedge sysclk) begin
		if (rst) begin
			g0_log.push_back('0);
			g1_log.push_back('0);
		end else begin
			g0_log.push_back(r0_in);
			g1_log.push_back(r1_in);
		end
		edge_cnt = edge_cnt + 1;
	end

	initial begin
		#(RUN_CYCLES * 100 + 10000);
		fail_stop("The watchdog expired before the tests finished");
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	// Galois LFSR, taps 16, 14, 13, 11
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic chan_word_t rand_word();
		chan_word_t w;
		for (int i = 0; i < NBITS; i++)
			w[i] = lfsr_bit();
		return w;
	endfunction

	function automatic ritc_group_t rand_group();
		ritc_group_t g;
		g.a = rand_word();
		g.b = rand_word();
		g.c = rand_word();
		return g;
	endfunction

	// Even sample positions take one value and odd positions the other
	function automatic ritc_group_t pattern_group(input int even_val, input int odd_val);
		chan_word_t  w;
		ritc_group_t g;
		for (int s = 0; s < NSAMP; s++)
			w[SBITS*s +: SBITS] = (s % 2 == 0) ? 3'(even_val) : 3'(odd_val);
		g.a = w;
		g.b = w;
		g.c = w;
		return g;
	endfunction

	////////////////////
	// Reference model
	////////////////////

	// Signed sample s of one channel word as it was logged at a given edge
	function automatic int sample_at(input int grp, input int ch, input int edge_idx,
	                                 input int s);
		ritc_group_t g;
		chan_word_t  w;
		if (edge_idx < 0)
			return 0;
		g = (grp == 0) ? g0_log[edge_idx] : g1_log[edge_idx];
		case (ch)
			0:       w = g.a;
			1:       w = g.b;
			default: w = g.c;
		endcase
		return $signed(w[SBITS*s +: SBITS]);
	endfunction

	// Windows of 2, 3 and 4 words end at the newest edge, A starts at offset 0
	function automatic score_t ref_max(input int grp, input int newest);
		int best;
		int score;
		int sum;
		int jb;
		int jc;
		best = 0;
		for (int k = 0; k < NCORR; k++) begin
			score = 0;
			for (int i = 0; i < NSAMP; i++) begin
				jb = DELAY_B[k] + i;
				jc = DELAY_C[k] + i;
				sum = sample_at(grp, 0, newest - 1, i)
				    + sample_at(grp, 1, newest - 2 + jb / NSAMP, jb % NSAMP)
				    + sample_at(grp, 2, newest - 3 + jc / NSAMP, jc % NSAMP);
				score = score + sum * sum;
			end
			if (score > best)
				best = score;
		end
		return score_t'(best);
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_score(input string name, input score_t got, input score_t exp);
		if (got !== exp)
			fail_stop($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
	                          input logic [31:0] exp);
		if (got !== exp)
			fail_stop($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_stop($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// The max output lags the storage by four edges, the storage lags the input by one
	task automatic check_maxima();
		int newest;
		newest = edge_cnt - 5;
		check_score("r0_max_o", r0_max, ref_max(0, newest));
		check_score("r1_max_o", r1_max, ref_max(1, newest));
	endtask

	task automatic drive_step(input ritc_group_t g0, input ritc_group_t g1,
	                          input logic sync_val);
		@(negedge sysclk);
		check_maxima();
		r0_in = g0;
		r1_in = g1;
		sync  = sync_val;
	endtask

	////////////////////
	// User bus
	////////////////////

	task automatic bus_access(input logic wr, input logic [10:0] addr,
	                          input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		@(negedge sysclk);
		user_cmd.wr    = wr;
		user_cmd.addr  = addr;
		user_cmd.wdata = wdata;
		user_req       = 1'b1;
		waited = 0;
		do begin
			@(negedge sysclk);
			waited++;
			if (!user_ack && waited >= 10)
				fail_stop($sformatf("No ack within 10 cycles for address 0x%h", addr));
		end while (!user_ack);
		// A trigger reaches the buffer on the edge that raised ack
		ack_edge = edge_cnt;
		rdata    = user_rdata;
		user_req = 1'b0;
		waited = 0;
		do begin
			@(negedge sysclk);
			waited++;
			if (user_ack && waited >= 10)
				fail_stop("Ack stayed high for 10 cycles after req was dropped");
		end while (user_ack);
	endtask

	task automatic bus_write(input logic [10:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		bus_access(1'b1, addr, wdata, unused);
	endtask

	task automatic bus_read(input logic [10:0] addr, output logic [31:0] rdata);
		bus_access(1'b0, addr, 32'd0, rdata);
	endtask

	task automatic check_entry(input int cap_start, input int entry, input int lane);
		logic [95:0] packed_ent;
		logic [31:0] rd;
		packed_ent = {g1_log[cap_start + entry].a, g0_log[cap_start + entry].a};
		bus_read(BUF_BASE + 11'(entry * 4 + lane), rd);
		check_word($sformatf("buffer entry %0d lane %0d", entry, lane), rd,
		           packed_ent[32*lane +: 32]);
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset();
		logic [31:0] rd;
		@(negedge sysclk);
		check_score("r0_max_o", r0_max, 12'd0);
		check_score("r1_max_o", r1_max, 12'd0);
		check_flag("user_ack_o", user_ack, 1'b0);
		bus_read(CTRL_ADDR, rd);
		check_word("status", rd, 32'd0);
	endtask

	task automatic test_constant();
		repeat (CONST_STEPS)
			drive_step(pattern_group(3, 3), pattern_group(-4, 3), 1'b0);
		// Each position sums to 9, so 16 * 81
		check_score("r0_max_o", r0_max, 12'd1296);
		repeat (CONST_STEPS)
			drive_step(pattern_group(-4, -4), pattern_group(1, -2), 1'b0);
		check_score("r0_max_o", r0_max, 12'd2304);
	endtask

	task automatic test_random();
		repeat (RAND_STEPS)
			drive_step(rand_group(), rand_group(), 1'b0);
	endtask

	task automatic test_capture();
		logic [31:0] rd;
		int          cap_start;
		bus_write(CTRL_ADDR, 32'h1);
		cap_start = ack_edge;
		for (int i = 0; i < CAP_STEPS; i++)
			drive_step(rand_group(), rand_group(), i == CAP_STEPS / 2);
		bus_read(CTRL_ADDR, rd);
		check_flag("done", rd[1], 1'b1);
		check_flag("sync_latch", rd[3], 1'b1);
		check_word("status", rd, 32'h0000_000A);
		foreach (PROBE_ENTRIES[p])
			for (int lane = 0; lane < 3; lane++)
				check_entry(cap_start, PROBE_ENTRIES[p], lane);
	endtask

	task automatic test_clear_and_stray();
		logic [31:0] rd;
		int          cap_start;
		bus_write(CTRL_ADDR, 32'h4);
		bus_read(CTRL_ADDR, rd);
		check_word("status", rd, 32'd0);
		bus_write(CTRL_ADDR, 32'h1);
		cap_start = ack_edge;
		repeat (RECAP_STEPS)
			drive_step(rand_group(), rand_group(), 1'b0);
		bus_read(CTRL_ADDR, rd);
		check_flag("done", rd[1], 1'b1);
		check_flag("sync_latch", rd[3], 1'b0);
		check_entry(cap_start, 5, 1);
		bus_read(11'h100, rd);
		check_word("unmapped read", rd, 32'd0);
		bus_read(BUF_BASE + 11'(5 * 4 + 3), rd);
		check_word("buffer lane 3", rd, 32'd0);
	endtask

	initial begin
		rst      = 1'b1;
		sync     = 1'b0;
		r0_in    = '0;
		r1_in    = '0;
		user_req = 1'b0;
		user_cmd = '0;
		repeat (RST_CYCLES) @(negedge sysclk);
		rst = 1'b0;

		test_reset();
		test_constant();
		test_random();
		test_capture();
		test_clear_and_stray();

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- files.f
hdl/corr_pkg.sv
hdl/ritc_input_storage.sv
hdl/quad_correlator.sv
hdl/sample_buffer.sv
hdl/user_bus_slave.sv
hdl/dual_ritc_correlator.sv
tb/tb_dual_ritc_correlator.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dual_ritc_correlator -f files.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
fi

if grep -q "Result: PASSED" "$LOG"; then
	exit 0
fi
exit 1
